// ==== sim.f ====
+incdir+bench
source/mem_bus_pkg.sv
source/sram_array.sv
source/sram_axi_ctrl.sv
source/bus_arbiter.sv
source/mem_subsystem.sv
bench/tb_mem_subsystem.sv

// ==== Makefile ====
TOP := tb_mem_subsystem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_checks.svh ====
// ---------------------------------------------------------------------------
// Compare tasks for read beats, write responses and grant order, with the
// check and error counters of the memory port testbench
// ---------------------------------------------------------------------------
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int check_count = 0;
int error_count = 0;

task automatic check_read_beat(input axi_r_t got, input axi_r_t exp, input string what);
    bit bad;
    check_count++;
    bad = (got.resp !== exp.resp) || (got.last !== exp.last);
    // data of an error beat carries no meaning
    if (exp.resp == resp_okay && got.data !== exp.data) begin
        bad = 1'b1;
    end
    if (bad) begin
        error_count++;
        $display("** Error (%0t ns): %s got data %h resp %s last %b", $time, what,
                 got.data, got.resp.name(), got.last);
        $display("         expected data %h resp %s last %b",
                 exp.data, exp.resp.name(), exp.last);
    end
endtask

task automatic check_write_resp(input axi_resp_e got, input axi_resp_e exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("** Error (%0t ns): %s got %s, expected %s", $time, what,
                 got.name(), exp.name());
    end
endtask

task automatic check_grant_order(input arb_grant_e got, input arb_grant_e exp,
                                 input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("** Error (%0t ns): %s was %s, expected %s", $time, what,
                 got.name(), exp.name());
    end
endtask

`endif

// ==== bench/tb_mem_subsystem.sv ====
// ---------------------------------------------------------------------------
// Testbench for the shared memory port: random IFU and MEMU traffic
// checked against a byte-lane model of the SRAM
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_mem_subsystem;
    import mem_bus_pkg::*;

    localparam int MEM_WORDS    = 64;
    localparam int max_beats    = 8;
    localparam int reset_cycles = 16;
    localparam int n_stores     = 24;
    localparam int n_random     = 40;
    localparam int beat_bound   = 16;
    // fill, partial stores, IFU bursts, priority, back-pressure, out of range
    localparam int n_trans = 2 * (MEM_WORDS / max_beats) + 2 * n_stores + max_beats + 3
                             + n_random + 5;
    localparam int watchdog_cycles = reset_cycles + n_trans * max_beats * beat_bound;

    logic      clk = 1'b0;
    logic      reset;
    axi_ar_t   ifu_ar;
    logic      ifu_arvalid;
    logic      ifu_arready;
    axi_r_t    ifu_r;
    logic      ifu_rvalid;
    logic      ifu_rready;
    axi_ar_t   mem_ar;
    logic      mem_arvalid;
    logic      mem_arready;
    axi_r_t    mem_r;
    logic      mem_rvalid;
    logic      mem_rready;
    axi_aw_t   mem_aw;
    logic      mem_awvalid;
    logic      mem_awready;
    axi_w_t    mem_w;
    logic      mem_wvalid;
    logic      mem_wready;
    axi_resp_e mem_b;
    logic      mem_bvalid;
    logic      mem_bready;

    // reference memory, one byte per lane
    logic [3:0][7:0] model [MEM_WORDS];
    logic [31:0]     wr_data [max_beats];
    logic [3:0]      wr_strb [max_beats];
    logic [3:0]      partial_strb [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                          4'b0011, 4'b0110, 4'b1100};
    // last accepted beat per master, index 1 is the IFU
    axi_r_t          prev_beat [2];
    bit              prev_valid [2] = '{1'b0, 1'b0};
    arb_grant_e      done_order [$];
    int              seed = 32'h798;
    int              test_checks = 0;
    int              test_errors = 0;

    `include "tb_checks.svh"

    always #20 clk = ~clk;

    mem_subsystem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem_subsystem (.*);

    function automatic axi_r_t expected_beat(input int unsigned word, input bit last);
        axi_r_t e;
        e.data = (word < MEM_WORDS) ? model[word] : 32'h0;
        e.resp = (word < MEM_WORDS) ? resp_okay : resp_slverr;
        e.last = last;
        return e;
    endfunction

    // store data comes in the low lanes and lands from the lowest strobed byte up
    function automatic void store_model(input int unsigned word, input logic [31:0] data,
                                        input logic [3:0] strb);
        int lo;
        lo = 0;
        for (int i = 3; i >= 0; i--) begin
            if (strb[i])
                lo = i;
        end
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                model[word][i] = data[8*(i-lo) +: 8];
        end
    endfunction

    function automatic void fill_random(input int beats);
        for (int b = 0; b < beats; b++) begin
            wr_data[b] = $random(seed);
            wr_strb[b] = 4'b1111;
        end
    endfunction

    task automatic write_burst(input int unsigned word, input int len, input bit stall);
        axi_resp_e exp_resp;
        exp_resp = resp_okay;
        mem_aw      <= '{addr: 32'(word * 4), len: 8'(len), size: word_size};
        mem_awvalid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!mem_awready);
        mem_awvalid <= 1'b0;
        for (int b = 0; b <= len; b++) begin
            mem_w      <= '{data: wr_data[b], strb: wr_strb[b], last: (b == len)};
            mem_wvalid <= 1'b1;
            do begin
                @(posedge clk);
            end while (!mem_wready);
            if (word + b >= MEM_WORDS)
                exp_resp = resp_slverr;
        end
        mem_wvalid <= 1'b0;
        do begin
            mem_bready <= stall ? (($random(seed) & 3) != 0) : 1'b1;
            @(posedge clk);
        end while (!(mem_bvalid && mem_bready));
        mem_bready <= 1'b0;
        check_write_resp(mem_b, exp_resp, "write response");
        for (int b = 0; b <= len; b++) begin
            if (word + b < MEM_WORDS)
                store_model(word + b, wr_data[b], wr_strb[b]);
        end
    endtask

    task automatic read_burst(input bit from_ifu, input int unsigned word, input int len,
                              input bit stall);
        axi_ar_t ar;
        axi_r_t  got;
        axi_r_t  held;
        axi_r_t  exp_beat;
        logic    rv;
        logic    rdy;
        bit      pending;
        bit      done;
        int      beat;
        ar      = '{addr: 32'(word * 4), len: 8'(len), size: word_size};
        pending = 1'b0;
        done    = 1'b0;
        beat    = 0;
        if (from_ifu) begin
            ifu_ar      <= ar;
            ifu_arvalid <= 1'b1;
        end else begin
            mem_ar      <= ar;
            mem_arvalid <= 1'b1;
        end
        do begin
            @(posedge clk);
        end while (!(from_ifu ? ifu_arready : mem_arready));
        if (from_ifu)
            ifu_arvalid <= 1'b0;
        else
            mem_arvalid <= 1'b0;
        while (!done) begin
            rdy = stall ? (($random(seed) & 3) != 0) : 1'b1;
            if (from_ifu)
                ifu_rready <= rdy;
            else
                mem_rready <= rdy;
            @(posedge clk);
            rv  = from_ifu ? ifu_rvalid : mem_rvalid;
            got = from_ifu ? ifu_r : mem_r;
            if (pending && !rv) begin
                error_count++;
                $display("%0t ns: read valid dropped before the beat was accepted", $time);
            end
            // before the first beat the port still shows the last accepted one
            if (!rv && !pending && prev_valid[from_ifu])
                check_read_beat(got, prev_beat[from_ifu], "held beat");
            if (rv && pending)
                check_read_beat(got, held, "stalled beat");
            if (rv && rdy) begin
                exp_beat = expected_beat(word + beat, beat == len);
                check_read_beat(got, exp_beat, "read beat");
                prev_beat[from_ifu]  = exp_beat;
                prev_valid[from_ifu] = 1'b1;
                beat++;
                pending = 1'b0;
                done    = got.last || beat > len;
            end else if (rv) begin
                held    = got;
                pending = 1'b1;
            end
        end
        if (from_ifu)
            ifu_rready <= 1'b0;
        else
            mem_rready <= 1'b0;
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, check_count - test_checks,
                 error_count - test_errors);
        test_checks = check_count;
        test_errors = error_count;
    endtask

    initial begin
        int unsigned w;
        int          len;
        reset       = 1'b1;
        ifu_ar      = '0;
        ifu_arvalid = 1'b0;
        ifu_rready  = 1'b0;
        mem_ar      = '0;
        mem_arvalid = 1'b0;
        mem_rready  = 1'b0;
        mem_aw      = '0;
        mem_awvalid = 1'b0;
        mem_w       = '0;
        mem_wvalid  = 1'b0;
        mem_bready  = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;

        // every word gets a known value before anything reads it
        for (int base = 0; base < MEM_WORDS; base += max_beats) begin
            fill_random(max_beats);
            write_burst(base, max_beats - 1, 1'b0);
        end
        for (int base = 0; base < MEM_WORDS; base += max_beats)
            read_burst(1'b0, base, max_beats - 1, 1'b0);
        end_test("word write and readback");

        repeat (n_stores) begin
            w          = {$random(seed)} % MEM_WORDS;
            wr_strb[0] = partial_strb[{$random(seed)} % 7];
            wr_data[0] = $random(seed);
            wr_data[0] &= ($countones(wr_strb[0]) == 1) ? 32'h0000_00ff : 32'h0000_ffff;
            write_burst(w, 0, 1'b0);
            read_burst(1'b0, w, 0, 1'b0);
        end
        end_test("partial stores");

        for (int l = 0; l < max_beats; l++) begin
            w = {$random(seed)} % (MEM_WORDS - l);
            read_burst(1'b1, w, l, 1'b0);
        end
        end_test("ifu bursts");

        // all three requests rise in the same idle cycle
        fill_random(4);
        fork
            begin
                write_burst(8, 3, 1'b0);
                done_order.push_back(grant_mem_write);
            end
            begin
                read_burst(1'b1, 20, 5, 1'b0);
                done_order.push_back(grant_ifu_read);
            end
            begin
                read_burst(1'b0, 40, 2, 1'b0);
                done_order.push_back(grant_mem_read);
            end
        join
        check_grant_order(done_order[0], grant_mem_write, "first completion");
        check_grant_order(done_order[1], grant_ifu_read, "second completion");
        check_grant_order(done_order[2], grant_mem_read, "third completion");
        end_test("priority");

        repeat (n_random) begin
            len = {$random(seed)} % max_beats;
            w   = {$random(seed)} % (MEM_WORDS - len);
            case ({$random(seed)} % 3)
                0: read_burst(1'b1, w, len, 1'b1);
                1: read_burst(1'b0, w, len, 1'b1);
                default: begin
                    fill_random(len + 1);
                    write_burst(w, len, 1'b1);
                end
            endcase
        end
        end_test("back-pressure");

        // both writes alias onto low words if the range check fails
        fill_random(2);
        write_burst(MEM_WORDS + 5, 1, 1'b0);
        fill_random(1);
        write_burst(32'h3fff_0000, 0, 1'b0);
        read_burst(1'b0, MEM_WORDS - 2, 3, 1'b0);
        read_burst(1'b1, MEM_WORDS + 5, 1, 1'b0);
        read_burst(1'b0, 0, 7, 1'b0);
        end_test("out-of-range addresses");

        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog: run hung, not finished after %0d cycles", watchdog_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== source/mem_subsystem.sv ====
// ---------------------------------------------------------------------------
// Shared memory port with arbiter, AXI4 SRAM controller and SRAM array
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module mem_subsystem #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                   clk,
    input  logic                   reset,
    // IFU read port
    input  mem_bus_pkg::axi_ar_t   ifu_ar,
    input  logic                   ifu_arvalid,
    output logic                   ifu_arready,
    output mem_bus_pkg::axi_r_t    ifu_r,
    output logic                   ifu_rvalid,
    input  logic                   ifu_rready,
    // MEMU port
    input  mem_bus_pkg::axi_ar_t   mem_ar,
    input  logic                   mem_arvalid,
    output logic                   mem_arready,
    output mem_bus_pkg::axi_r_t    mem_r,
    output logic                   mem_rvalid,
    input  logic                   mem_rready,
    input  mem_bus_pkg::axi_aw_t   mem_aw,
    input  logic                   mem_awvalid,
    output logic                   mem_awready,
    input  mem_bus_pkg::axi_w_t    mem_w,
    input  logic                   mem_wvalid,
    output logic                   mem_wready,
    output mem_bus_pkg::axi_resp_e mem_b,
    output logic                   mem_bvalid,
    input  logic                   mem_bready
);
    import mem_bus_pkg::*;

    localparam int ADDR_W = $clog2(MEM_WORDS);

    // downstream bus
    axi_ar_t   s_ar;
    axi_aw_t   s_aw;
    axi_w_t    s_w;
    axi_r_t    s_r;
    axi_resp_e s_b;
    logic      s_arvalid;
    logic      s_arready;
    logic      s_awvalid;
    logic      s_awready;
    logic      s_wvalid;
    logic      s_wready;
    logic      s_rvalid;
    logic      s_rready;
    logic      s_bvalid;
    logic      s_bready;

    // array port
    logic [ADDR_W-1:0] sram_addr;
    logic              sram_rd_en;
    logic              sram_wr_en;
    logic [3:0]        sram_be;
    logic [31:0]       sram_wdata;
    logic [31:0]       sram_rdata;

    bus_arbiter u_bus_arbiter (
        .clk         (clk),
        .reset       (reset),
        .ifu_ar      (ifu_ar),
        .ifu_arvalid (ifu_arvalid),
        .ifu_arready (ifu_arready),
        .ifu_r       (ifu_r),
        .ifu_rvalid  (ifu_rvalid),
        .ifu_rready  (ifu_rready),
        .mem_ar      (mem_ar),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_r       (mem_r),
        .mem_rvalid  (mem_rvalid),
        .mem_rready  (mem_rready),
        .mem_aw      (mem_aw),
        .mem_awvalid (mem_awvalid),
        .mem_awready (mem_awready),
        .mem_w       (mem_w),
        .mem_wvalid  (mem_wvalid),
        .mem_wready  (mem_wready),
        .mem_b       (mem_b),
        .mem_bvalid  (mem_bvalid),
        .mem_bready  (mem_bready),
        .s_ar        (s_ar),
        .s_arvalid   (s_arvalid),
        .s_arready   (s_arready),
        .s_aw        (s_aw),
        .s_awvalid   (s_awvalid),
        .s_awready   (s_awready),
        .s_w         (s_w),
        .s_wvalid    (s_wvalid),
        .s_wready    (s_wready),
        .s_r         (s_r),
        .s_rvalid    (s_rvalid),
        .s_rready    (s_rready),
        .s_b         (s_b),
        .s_bvalid    (s_bvalid),
        .s_bready    (s_bready)
    );

    sram_axi_ctrl #(
        .MEM_WORDS (MEM_WORDS)
    ) u_sram_axi_ctrl (
        .clk       (clk),
        .reset     (reset),
        .s_ar      (s_ar),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_aw      (s_aw),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_w       (s_w),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_r       (s_r),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .s_b       (s_b),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .mem_addr  (sram_addr),
        .mem_rd_en (sram_rd_en),
        .mem_wr_en (sram_wr_en),
        .mem_be    (sram_be),
        .mem_wdata (sram_wdata),
        .mem_rdata (sram_rdata)
    );

    sram_array #(
        .MEM_WORDS (MEM_WORDS)
    ) u_sram_array (
        .clk   (clk),
        .addr  (sram_addr),
        .rd_en (sram_rd_en),
        .wr_en (sram_wr_en),
        .be    (sram_be),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

endmodule

// ==== source/bus_arbiter.sv ====
// ---------------------------------------------------------------------------
// Fixed-priority AXI4 arbiter between the fetch and load/store masters,
// with read-data hold registers and store lane alignment
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                   clk,
    input  logic                   reset,
    // IFU read port
    input  mem_bus_pkg::axi_ar_t   ifu_ar,
    input  logic                   ifu_arvalid,
    output logic                   ifu_arready,
    output mem_bus_pkg::axi_r_t    ifu_r,
    output logic                   ifu_rvalid,
    input  logic                   ifu_rready,
    // MEMU port
    input  mem_bus_pkg::axi_ar_t   mem_ar,
    input  logic                   mem_arvalid,
    output logic                   mem_arready,
    output mem_bus_pkg::axi_r_t    mem_r,
    output logic                   mem_rvalid,
    input  logic                   mem_rready,
    input  mem_bus_pkg::axi_aw_t   mem_aw,
    input  logic                   mem_awvalid,
    output logic                   mem_awready,
    input  mem_bus_pkg::axi_w_t    mem_w,
    input  logic                   mem_wvalid,
    output logic                   mem_wready,
    output mem_bus_pkg::axi_resp_e mem_b,
    output logic                   mem_bvalid,
    input  logic                   mem_bready,
    // downstream bus
    output mem_bus_pkg::axi_ar_t   s_ar,
    output logic                   s_arvalid,
    input  logic                   s_arready,
    output mem_bus_pkg::axi_aw_t   s_aw,
    output logic                   s_awvalid,
    input  logic                   s_awready,
    output mem_bus_pkg::axi_w_t    s_w,
    output logic                   s_wvalid,
    input  logic                   s_wready,
    input  mem_bus_pkg::axi_r_t    s_r,
    input  logic                   s_rvalid,
    output logic                   s_rready,
    input  mem_bus_pkg::axi_resp_e s_b,
    input  logic                   s_bvalid,
    output logic                   s_bready
);
    import mem_bus_pkg::*;

    arb_grant_e  grant_q;
    axi_r_t      ifu_r_q;
    axi_r_t      mem_r_q;
    logic [31:0] wdata_aligned;
    logic        rd_done;
    logic        wr_done;
    logic        wr_grant;

    assign rd_done  = s_rvalid && s_rready && s_r.last;
    assign wr_done  = s_bvalid && s_bready;
    assign wr_grant = (grant_q == grant_mem_write);

    // write first, then fetch, then load
    always_ff @(posedge clk) begin
        if (reset) begin
            grant_q <= grant_none;
        end else begin
            case (grant_q)
                grant_none: begin
                    if (mem_awvalid) begin
                        grant_q <= grant_mem_write;
                    end else if (ifu_arvalid) begin
                        grant_q <= grant_ifu_read;
                    end else if (mem_arvalid) begin
                        grant_q <= grant_mem_read;
                    end
                end
                grant_mem_write: begin
                    if (wr_done) begin
                        grant_q <= grant_none;
                    end
                end
                default: begin
                    if (rd_done) begin
                        grant_q <= grant_none;
                    end
                end
            endcase
        end
    end

    // read address and read data steering
    always_comb begin
        s_ar        = '0;
        s_arvalid   = 1'b0;
        s_rready    = 1'b0;
        ifu_arready = 1'b0;
        mem_arready = 1'b0;
        case (grant_q)
            grant_ifu_read: begin
                s_ar        = ifu_ar;
                s_arvalid   = ifu_arvalid;
                s_rready    = ifu_rready;
                ifu_arready = s_arready;
            end
            grant_mem_read: begin
                s_ar        = mem_ar;
                s_arvalid   = mem_arvalid;
                s_rready    = mem_rready;
                mem_arready = s_arready;
            end
            default: begin
            end
        endcase
    end

    assign ifu_rvalid = (grant_q == grant_ifu_read) && s_rvalid;
    assign mem_rvalid = (grant_q == grant_mem_read) && s_rvalid;

    // last beat seen by each master
    always_ff @(posedge clk) begin
        if (ifu_rvalid) begin
            ifu_r_q <= s_r;
        end
        if (mem_rvalid) begin
            mem_r_q <= s_r;
        end
    end

    assign ifu_r = ifu_rvalid ? s_r : ifu_r_q;
    assign mem_r = mem_rvalid ? s_r : mem_r_q;

    // store data arrives in the low lanes
    always_comb begin
        case (mem_w.strb)
            4'b0001: wdata_aligned = {24'b0, mem_w.data[7:0]};
            4'b0010: wdata_aligned = {16'b0, mem_w.data[7:0], 8'b0};
            4'b0100: wdata_aligned = {8'b0, mem_w.data[7:0], 16'b0};
            4'b1000: wdata_aligned = {mem_w.data[7:0], 24'b0};
            4'b0011: wdata_aligned = {16'b0, mem_w.data[15:0]};
            4'b0110: wdata_aligned = {8'b0, mem_w.data[15:0], 8'b0};
            4'b1100: wdata_aligned = {mem_w.data[15:0], 16'b0};
            4'b1111: wdata_aligned = mem_w.data;
            default: wdata_aligned = 32'b0;
        endcase
    end

    // write channels belong to the MEMU only
    always_comb begin
        s_aw      = '0;
        s_w       = '0;
        if (wr_grant) begin
            s_aw      = mem_aw;
            s_w.data  = wdata_aligned;
            s_w.strb  = mem_w.strb;
            s_w.last  = mem_w.last;
        end
    end

    assign s_awvalid   = wr_grant && mem_awvalid;
    assign s_wvalid    = wr_grant && mem_wvalid;
    assign s_bready    = wr_grant && mem_bready;
    assign mem_awready = wr_grant && s_awready;
    assign mem_wready  = wr_grant && s_wready;
    assign mem_bvalid  = wr_grant && s_bvalid;
    assign mem_b       = wr_grant ? s_b : resp_okay;

    // controller responses only arrive while their master holds the grant
    a_rvalid_granted: assert property (@(posedge clk) disable iff (reset)
        s_rvalid |-> (grant_q == grant_ifu_read || grant_q == grant_mem_read));

    a_bvalid_granted: assert property (@(posedge clk) disable iff (reset)
        s_bvalid |-> wr_grant);

endmodule

// ==== source/sram_axi_ctrl.sv ====
// ---------------------------------------------------------------------------
// AXI4 slave for the on-chip SRAM with incrementing bursts,
// address range check and per-beat responses
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module sram_axi_ctrl #(
    parameter int  MEM_WORDS = 1024,
    localparam int ADDR_W    = $clog2(MEM_WORDS)
) (
    input  logic                   clk,
    input  logic                   reset,
    input  mem_bus_pkg::axi_ar_t   s_ar,
    input  logic                   s_arvalid,
    output logic                   s_arready,
    input  mem_bus_pkg::axi_aw_t   s_aw,
    input  logic                   s_awvalid,
    output logic                   s_awready,
    input  mem_bus_pkg::axi_w_t    s_w,
    input  logic                   s_wvalid,
    output logic                   s_wready,
    output mem_bus_pkg::axi_r_t    s_r,
    output logic                   s_rvalid,
    input  logic                   s_rready,
    output mem_bus_pkg::axi_resp_e s_b,
    output logic                   s_bvalid,
    input  logic                   s_bready,
    output logic [ADDR_W-1:0]      mem_addr,
    output logic                   mem_rd_en,
    output logic                   mem_wr_en,
    output logic [3:0]             mem_be,
    output logic [31:0]            mem_wdata,
    input  logic [31:0]            mem_rdata
);
    import mem_bus_pkg::*;

    ctrl_state_e state_q;
    logic [29:0] word_q;
    logic [29:0] word_next;
    logic [29:0] issue_word;
    logic [7:0]  beat_q;
    logic [7:0]  len_q;
    logic        size_err_q;
    logic        werr_q;
    logic        rvalid_q;
    logic        cur_err;
    logic        rd_issue;
    logic        r_hs;
    logic        w_hs;
    logic        last_beat;

    function automatic logic in_range(input logic [29:0] word);
        return word < 30'(MEM_WORDS);
    endfunction

    assign word_next = word_q + 30'd1;
    assign last_beat = (beat_q == len_q);
    assign cur_err   = !in_range(word_q) || size_err_q;
    assign r_hs      = s_rvalid && s_rready;
    assign w_hs      = s_wvalid && s_wready;

    // first read goes out the cycle after AR, later ones on each accepted beat
    assign rd_issue   = (state_q == ctrl_read) && (!rvalid_q || (s_rready && !last_beat));
    assign issue_word = rvalid_q ? word_next : word_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q  <= ctrl_idle;
            rvalid_q <= 1'b0;
            werr_q   <= 1'b0;
        end else begin
            case (state_q)
                ctrl_idle: begin
                    if (s_arvalid) begin
                        state_q <= ctrl_read;
                    end else if (s_awvalid) begin
                        state_q <= ctrl_write;
                        werr_q  <= 1'b0;
                    end
                end
                ctrl_read: begin
                    if (rd_issue) begin
                        rvalid_q <= 1'b1;
                    end else if (r_hs) begin
                        rvalid_q <= 1'b0;
                        state_q  <= ctrl_idle;
                    end
                end
                ctrl_write: begin
                    if (w_hs) begin
                        werr_q <= werr_q || cur_err;
                        if (s_w.last) begin
                            state_q <= ctrl_resp;
                        end
                    end
                end
                default: begin
                    if (s_bready) begin
                        state_q <= ctrl_idle;
                    end
                end
            endcase
        end
    end

    // burst address and beat count
    always_ff @(posedge clk) begin
        if (state_q == ctrl_idle) begin
            word_q     <= s_arvalid ? s_ar.addr[31:2] : s_aw.addr[31:2];
            len_q      <= s_arvalid ? s_ar.len : s_aw.len;
            size_err_q <= s_arvalid ? (s_ar.size != word_size) : (s_aw.size != word_size);
            beat_q     <= 8'd0;
        end else if ((r_hs && !last_beat) || w_hs) begin
            word_q <= word_next;
            beat_q <= beat_q + 8'd1;
        end
    end

    assign s_arready = (state_q == ctrl_idle);
    assign s_awready = (state_q == ctrl_idle) && !s_arvalid;
    assign s_wready  = (state_q == ctrl_write);

    assign s_rvalid  = rvalid_q;
    assign s_r.data  = cur_err ? 32'b0 : mem_rdata;
    assign s_r.resp  = cur_err ? resp_slverr : resp_okay;
    assign s_r.last  = last_beat;

    assign s_bvalid  = (state_q == ctrl_resp);
    assign s_b       = werr_q ? resp_slverr : resp_okay;

    // out of range beats never touch the array
    assign mem_addr  = (state_q == ctrl_write) ? word_q[ADDR_W-1:0] : issue_word[ADDR_W-1:0];
    assign mem_rd_en = rd_issue && in_range(issue_word);
    assign mem_wr_en = w_hs && !cur_err;
    assign mem_be    = s_w.strb;
    assign mem_wdata = s_w.data;

    // no beat follows the accepted last one
    a_rlast_final: assert property (@(posedge clk) disable iff (reset)
        r_hs && s_r.last |=> !s_rvalid);

    // the beat count never runs past the burst length
    a_beat_bound: assert property (@(posedge clk) disable iff (reset)
        s_rvalid |-> beat_q <= len_q);

    a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_r));

endmodule

// ==== source/sram_array.sv ====
// ---------------------------------------------------------------------------
// Word-wide SRAM with byte write enables and a registered read port
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module sram_array #(
    parameter int  MEM_WORDS = 1024,
    localparam int ADDR_W    = $clog2(MEM_WORDS)
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] addr,
    input  logic              rd_en,
    input  logic              wr_en,
    input  logic [3:0]        be,
    input  logic [31:0]       wdata,
    output logic [31:0]       rdata
);

    logic [31:0] mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // output holds its last word while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[addr];
        end
    end

endmodule

// ==== source/mem_bus_pkg.sv ====
// ---------------------------------------------------------------------------
// Shared AXI4 channel payloads and state encodings for the
// processor memory port
// ---------------------------------------------------------------------------

package mem_bus_pkg;

    // size code of a 4-byte beat
    localparam logic [2:0] word_size = 3'd2;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_e;

    typedef enum logic [1:0] {
        grant_none      = 2'd0,
        grant_ifu_read  = 2'd1,
        grant_mem_read  = 2'd2,
        grant_mem_write = 2'd3
    } arb_grant_e;

    typedef enum logic [1:0] {
        ctrl_idle  = 2'd0,
        ctrl_read  = 2'd1,
        ctrl_write = 2'd2,
        ctrl_resp  = 2'd3
    } ctrl_state_e;

    // len is beats minus one
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [31:0] data;
        axi_resp_e   resp;
        logic        last;
    } axi_r_t;

endpackage
